// ==== logic/wt_cache.sv ====
`timescale 1ns/1ns

module wt_cache
   import wt_cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Host port
   input  logic                   req,
   input  logic [ADDR_W-NBYTES_W:0] addr,
   input  data_t                  wdata,
   input  strb_t                  wstrb,
   output data_t                  rdata,
   output logic                   ack,
   // Memory port
   output logic                   be_req,
   output word_addr_t             be_addr,
   output data_t                  be_wdata,
   output strb_t                  be_wstrb,
   input  data_t                  be_rdata,
   input  logic                   be_ack,
   // Invalidate and write-empty chain
   input  logic                   invalidate_in,
   output logic                   invalidate_out,
   input  logic                   wtb_empty_in,
   output logic                   wtb_empty_out
);

   // Front end to cache memory
   logic       data_req, data_ack;
   word_addr_t data_addr;
   data_t      data_wdata, data_rdata;
   strb_t      data_wstrb;

   // Front end to control
   logic       ctrl_req, ctrl_ack, ctrl_write;
   ctrl_addr_t ctrl_addr;
   data_t      ctrl_wdata, ctrl_rdata;
   logic       ctrl_invalidate;

   // Cache memory to back end
   logic       write_req, write_ack;
   word_addr_t write_addr;
   data_t      write_wdata;
   strb_t      write_wstrb;
   logic       read_req, read_ack;
   word_addr_t read_addr;
   data_t      read_rdata;

   // Event pulses and status
   logic       read_hit, read_miss, write_hit, write_miss, write_idle;

   assign invalidate_out = ctrl_invalidate | invalidate_in;  // Also drives our own flush
   assign wtb_empty_out  = write_idle & wtb_empty_in;

   wt_cache_front_end front_end_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .data_req   (data_req),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_wstrb (data_wstrb),
      .data_rdata (data_rdata),
      .data_ack   (data_ack),
      .ctrl_req   (ctrl_req),
      .ctrl_addr  (ctrl_addr),
      .ctrl_wdata (ctrl_wdata),
      .ctrl_write (ctrl_write),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ack   (ctrl_ack)
   );

   wt_cache_memory cache_memory_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .data_req    (data_req),
      .data_addr   (data_addr),
      .data_wdata  (data_wdata),
      .data_wstrb  (data_wstrb),
      .data_rdata  (data_rdata),
      .data_ack    (data_ack),
      .write_req   (write_req),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ack   (write_ack),
      .read_req    (read_req),
      .read_addr   (read_addr),
      .read_rdata  (read_rdata),
      .read_ack    (read_ack),
      .invalidate  (invalidate_out),
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss),
      .write_idle  (write_idle)
   );

   wt_cache_back_end back_end_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .write_req   (write_req),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ack   (write_ack),
      .read_req    (read_req),
      .read_addr   (read_addr),
      .read_rdata  (read_rdata),
      .read_ack    (read_ack),
      .be_req      (be_req),
      .be_addr     (be_addr),
      .be_wdata    (be_wdata),
      .be_wstrb    (be_wstrb),
      .be_rdata    (be_rdata),
      .be_ack      (be_ack)
   );

   wt_cache_control control_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl_req   (ctrl_req),
      .ctrl_addr  (ctrl_addr),
      .ctrl_wdata (ctrl_wdata),
      .ctrl_write (ctrl_write),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ack   (ctrl_ack),
      .read_hit   (read_hit),
      .read_miss  (read_miss),
      .write_hit  (write_hit),
      .write_miss (write_miss),
      .write_idle (write_idle),
      .invalidate (ctrl_invalidate)
   );

endmodule

// ==== logic/wt_cache_back_end.sv ====
`timescale 1ns/1ns

module wt_cache_back_end
   import wt_cache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Write channel
   input  logic       write_req,
   input  word_addr_t write_addr,
   input  data_t      write_wdata,
   input  strb_t      write_wstrb,
   output logic       write_ack,
   // Read channel
   input  logic       read_req,
   input  word_addr_t read_addr,
   output data_t      read_rdata,
   output logic       read_ack,
   // Memory port
   output logic       be_req,
   output word_addr_t be_addr,
   output data_t      be_wdata,
   output strb_t      be_wstrb,
   input  data_t      be_rdata,
   input  logic       be_ack
);

   be_state_t state;
   logic      owner_write;  // Transfer in flight belongs to the write channel
   logic      take_write;
   logic      take_read;

   // A channel still shows req in its ack cycle, so skip it then
   assign take_write = (state == BE_IDLE) & write_req & ~write_ack;
   assign take_read  = (state == BE_IDLE) & read_req & ~read_ack & ~take_write;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= BE_IDLE;
         owner_write <= 1'b0;
         write_ack   <= 1'b0;
         read_ack    <= 1'b0;
      end else begin
         write_ack <= 1'b0;  // Acks are single pulses
         read_ack  <= 1'b0;
         case (state)
            BE_IDLE: begin
               if (take_write || take_read) begin
                  state       <= BE_BUSY;
                  owner_write <= take_write;
               end
            end
            BE_BUSY: begin
               if (be_ack) begin
                  state     <= BE_IDLE;
                  write_ack <= owner_write;
                  read_ack  <= ~owner_write;
               end
            end
            default: state <= BE_IDLE;
         endcase
      end
   end

   // Latched transfer fields
   always_ff @(posedge clk) begin
      if (take_write) begin
         be_addr  <= write_addr;
         be_wdata <= write_wdata;
         be_wstrb <= write_wstrb;
      end else if (take_read) begin
         be_addr  <= read_addr;
         be_wdata <= '0;
         be_wstrb <= '0;   // Zero strobe is a read
      end
      if (state == BE_BUSY && be_ack) read_rdata <= be_rdata;
   end

   assign be_req = (state == BE_BUSY);

endmodule

// ==== logic/wt_cache_control.sv ====
`timescale 1ns/1ns

module wt_cache_control
   import wt_cache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ctrl_req,
   input  ctrl_addr_t ctrl_addr,
   input  data_t      ctrl_wdata,
   input  logic       ctrl_write,
   output data_t      ctrl_rdata,
   output logic       ctrl_ack,
   input  logic       read_hit,
   input  logic       read_miss,
   input  logic       write_hit,
   input  logic       write_miss,
   input  logic       write_idle,
   output logic       invalidate
);

   data_t      cnt [4];    // Same order as the counter addresses
   logic [3:0] events;
   logic       access;     // First cycle of a control access
   logic       do_clear;
   data_t      rdata_nxt;

   assign events   = {write_miss, write_hit, read_miss, read_hit};
   assign access   = ctrl_req & ~ctrl_ack;
   assign do_clear = access & ctrl_write & (ctrl_addr == CTRL_CLEAR);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < 4; i++) cnt[i] <= '0;
      end else begin
         ctrl_ack   <= access;  // Answer one cycle after the request shows
         invalidate <= access & ctrl_write & (ctrl_addr == CTRL_INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            if (do_clear) cnt[i] <= '0;
            else if (events[i] && cnt[i] != '1) cnt[i] <= cnt[i] + 1'b1;  // Saturate
         end
      end
   end

   // Read decode, commands return zero
   always_comb begin
      rdata_nxt = '0;
      if (!ctrl_write) begin
         case (ctrl_addr)
            CTRL_RD_HIT:  rdata_nxt = cnt[0];
            CTRL_RD_MISS: rdata_nxt = cnt[1];
            CTRL_WR_HIT:  rdata_nxt = cnt[2];
            CTRL_WR_MISS: rdata_nxt = cnt[3];
            CTRL_STATUS:  rdata_nxt = data_t'(write_idle);
            default:      rdata_nxt = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (access) ctrl_rdata <= rdata_nxt;
   end

endmodule

// ==== logic/wt_cache_front_end.sv ====
`timescale 1ns/1ns

module wt_cache_front_end
   import wt_cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Host side
   input  logic                   req,
   input  logic [ADDR_W-NBYTES_W:0] addr,  // Top bit picks the control space
   input  data_t                  wdata,
   input  strb_t                  wstrb,
   output data_t                  rdata,
   output logic                   ack,
   // Cache memory side
   output logic                   data_req,
   output word_addr_t             data_addr,
   output data_t                  data_wdata,
   output strb_t                  data_wstrb,
   input  data_t                  data_rdata,
   input  logic                   data_ack,
   // Control side
   output logic                   ctrl_req,
   output ctrl_addr_t             ctrl_addr,
   output data_t                  ctrl_wdata,
   output logic                   ctrl_write,
   input  data_t                  ctrl_rdata,
   input  logic                   ctrl_ack
);

   logic       busy;      // A request is held and not yet answered
   logic       sel_ctrl;  // Held request targets the control block
   word_addr_t addr_reg;
   data_t      wdata_reg;
   strb_t      wstrb_reg;
   logic       accept;

   assign accept = req & ~busy;  // New requests only while idle

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         sel_ctrl <= 1'b0;
      end else if (accept) begin
         busy     <= 1'b1;
         sel_ctrl <= addr[ADDR_W-NBYTES_W];
      end else if (ack) begin
         busy <= 1'b0;  // Done, free for the next one
      end
   end

   // Request payload, only meaningful while busy
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_reg  <= addr[ADDR_W-NBYTES_W-1:0];
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;
      end
   end

   assign data_req   = busy & ~sel_ctrl;
   assign data_addr  = addr_reg;
   assign data_wdata = wdata_reg;
   assign data_wstrb = wstrb_reg;

   assign ctrl_req   = busy & sel_ctrl;
   assign ctrl_addr  = addr_reg[CTRL_ADDR_W-1:0];  // Low word address bits only
   assign ctrl_wdata = wdata_reg;
   assign ctrl_write = |wstrb_reg;                 // Any strobe makes it a write

   // Answer from whichever target owns the request
   assign rdata = sel_ctrl ? ctrl_rdata : data_rdata;
   assign ack   = busy & (sel_ctrl ? ctrl_ack : data_ack);

endmodule

// ==== logic/wt_cache_memory.sv ====
`timescale 1ns/1ns

module wt_cache_memory
   import wt_cache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Front end
   input  logic       data_req,
   input  word_addr_t data_addr,
   input  data_t      data_wdata,
   input  strb_t      data_wstrb,
   output data_t      data_rdata,
   output logic       data_ack,
   // Back-end write channel
   output logic       write_req,
   output word_addr_t write_addr,
   output data_t      write_wdata,
   output strb_t      write_wstrb,
   input  logic       write_ack,
   // Back-end read channel
   output logic       read_req,
   output word_addr_t read_addr,
   input  data_t      read_rdata,
   input  logic       read_ack,
   // Control
   input  logic       invalidate,
   output logic       read_hit,
   output logic       read_miss,
   output logic       write_hit,
   output logic       write_miss,
   output logic       write_idle
);

   localparam int NLINES = 2**NLINES_W;
   localparam int NWORDS = 2**WORD_OFFSET_W;

   data_t             data_mem [NLINES][NWORDS];
   tag_t              tag_mem  [NLINES];
   logic [NLINES-1:0] valid;

   mem_state_t state;
   offset_t    fill_cnt;   // Next word of the line to fetch
   logic       fill_done;  // Lookup after a fill answers without counting

   // Address split, tag | index | offset
   tag_t    tag;
   index_t  idx;
   offset_t offset;
   logic    is_write;
   logic    hit;
   logic    in_lookup;
   data_t   merged;

   assign offset    = data_addr[WORD_OFFSET_W-1:0];
   assign idx       = data_addr[WORD_OFFSET_W +: NLINES_W];
   assign tag       = data_addr[WORD_OFFSET_W+NLINES_W +: TAG_W];
   assign is_write  = |data_wstrb;
   assign hit       = valid[idx] & (tag_mem[idx] == tag);
   assign in_lookup = (state == MEM_LOOKUP);

   // Strobed bytes over the cached word
   always_comb begin
      merged = data_mem[idx][offset];
      for (int b = 0; b < 2**NBYTES_W; b++) begin
         if (data_wstrb[b]) merged[8*b +: 8] = data_wdata[8*b +: 8];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= MEM_IDLE;
         fill_cnt  <= '0;
         fill_done <= 1'b0;
         valid     <= '0;
      end else begin
         case (state)
            MEM_IDLE: begin
               if (data_req) state <= MEM_LOOKUP;
            end
            MEM_LOOKUP: begin
               if (is_write) begin
                  state <= MEM_WRITE;           // Hit or miss, always go through
               end else if (hit || fill_done) begin
                  state     <= MEM_IDLE;
                  fill_done <= 1'b0;
               end else begin
                  state    <= MEM_FILL;
                  fill_cnt <= '0;
               end
            end
            MEM_FILL: begin
               if (read_ack) begin
                  fill_cnt <= fill_cnt + 1'b1;
                  if (fill_cnt == offset_t'(NWORDS-1)) begin
                     valid[idx] <= 1'b1;       // Line complete
                     fill_done  <= 1'b1;
                     state      <= MEM_LOOKUP;
                  end
               end
            end
            MEM_WRITE: begin
               if (write_ack) state <= MEM_IDLE;
            end
            default: state <= MEM_IDLE;
         endcase
         if (invalidate) valid <= '0;  // Wins over a line being set
      end
   end

   // Line storage
   always_ff @(posedge clk) begin
      if (in_lookup && is_write && hit) data_mem[idx][offset] <= merged;
      if (state == MEM_FILL && read_ack) begin
         data_mem[idx][fill_cnt] <= read_rdata;
         if (fill_cnt == offset_t'(NWORDS-1)) tag_mem[idx] <= tag;
      end
   end

   assign data_rdata = data_mem[idx][offset];
   assign data_ack   = (in_lookup & ~is_write & (hit | fill_done))
                     | ((state == MEM_WRITE) & write_ack);

   // Write-through of the host word as given
   assign write_req   = (state == MEM_WRITE);
   assign write_addr  = data_addr;
   assign write_wdata = data_wdata;
   assign write_wstrb = data_wstrb;

   // Line fill, offsets 0 to 3 in order
   assign read_req  = (state == MEM_FILL);
   assign read_addr = {tag, idx, fill_cnt};

   // One-cycle event pulses, fill replays are not counted
   assign read_hit   = in_lookup & ~is_write & hit & ~fill_done;
   assign read_miss  = in_lookup & ~is_write & ~hit & ~fill_done;
   assign write_hit  = in_lookup & is_write & hit;
   assign write_miss = in_lookup & is_write & ~hit;
   assign write_idle = (state != MEM_WRITE);

endmodule

// ==== logic/wt_cache_pkg.sv ====
package wt_cache_pkg;

   // Address and data geometry
   localparam int ADDR_W        = 16;  // Byte address space
   localparam int DATA_W        = 32;
   localparam int NBYTES_W      = 2;   // Byte select bits dropped from word addresses
   localparam int NLINES_W      = 4;   // 16 lines
   localparam int WORD_OFFSET_W = 2;   // 4 words per line
   localparam int TAG_W         = ADDR_W - NBYTES_W - NLINES_W - WORD_OFFSET_W;
   localparam int CTRL_ADDR_W   = 3;

   typedef logic [ADDR_W-NBYTES_W-1:0] word_addr_t;
   typedef logic [DATA_W-1:0]          data_t;
   typedef logic [2**NBYTES_W-1:0]     strb_t;
   typedef logic [TAG_W-1:0]           tag_t;
   typedef logic [NLINES_W-1:0]        index_t;
   typedef logic [WORD_OFFSET_W-1:0]   offset_t;
   typedef logic [CTRL_ADDR_W-1:0]     ctrl_addr_t;

   // Control register map, word addresses
   localparam ctrl_addr_t CTRL_RD_HIT     = 3'd0;  // Counters are read only
   localparam ctrl_addr_t CTRL_RD_MISS    = 3'd1;
   localparam ctrl_addr_t CTRL_WR_HIT     = 3'd2;
   localparam ctrl_addr_t CTRL_WR_MISS    = 3'd3;
   localparam ctrl_addr_t CTRL_STATUS     = 3'd4;  // Bit 0 is write idle
   localparam ctrl_addr_t CTRL_INVALIDATE = 3'd5;  // Write drops all lines
   localparam ctrl_addr_t CTRL_CLEAR      = 3'd6;  // Write zeroes the counters

   // Cache memory sequencer
   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_LOOKUP,  // Tag compare, hit answers here
      MEM_FILL,    // Four word reads from the back end
      MEM_WRITE    // Write-through in flight
   } mem_state_t;

   // Back-end port owner
   typedef enum logic {
      BE_IDLE,
      BE_BUSY
   } be_state_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -f wt_cache.f --top-module wt_cache_tb -o wt_cache_sim \
   && ./obj_dir/wt_cache_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== verif/wt_cache_tb.sv ====
`timescale 1ns/1ns

module wt_cache_tb
   import wt_cache_pkg::*;
();

   localparam int          CLK_HALF      = 50;
   localparam int          RST_CYCLES    = 10;
   localparam int          CYCLES_PER_OP = 40;            // Budget per table row
   localparam int          MEM_WORDS     = 2**(ADDR_W-NBYTES_W);
   localparam logic [31:0] SEED          = 32'h81efad68;

   typedef enum int {
      OP_RD,     // Host read of the cached space
      OP_WR,     // Host write that always goes through
      OP_CRD,    // Control register read
      OP_CWR,    // Control command write
      OP_PIN,    // Pulse on invalidate_in
      OP_EMPTY   // Drive wtb_empty_in from wdata bit 0
   } op_kind_t;

   logic                     clk;
   logic                     rst_n;
   logic                     req;
   logic [ADDR_W-NBYTES_W:0] addr;
   data_t                    wdata;
   strb_t                    wstrb;
   data_t                    rdata;
   logic                     ack;
   logic                     be_req;
   word_addr_t               be_addr;
   data_t                    be_wdata;
   strb_t                    be_wstrb;
   data_t                    be_rdata;
   logic                     be_ack;
   logic                     invalidate_in;
   logic                     invalidate_out;
   logic                     wtb_empty_in;
   logic                     wtb_empty_out;

   data_t      mem    [MEM_WORDS];  // Main memory behind the back end
   data_t      shadow [MEM_WORDS];  // Expected memory contents
   logic [15:0] shadow_valid;
   tag_t       shadow_tag [16];
   data_t      exp_cnt [4];         // rd hit, rd miss, wr hit, wr miss

   // Operation table
   string      op_name    [$];
   op_kind_t   op_kind    [$];
   word_addr_t op_addr    [$];
   data_t      op_wdata   [$];
   strb_t      op_wstrb   [$];
   logic       op_use_exp [$];
   data_t      op_exp     [$];

   logic test_ok;
   int   n_pass = 0;
   int   n_fail = 0;
   int   cycles = 0;
   int   cycle_limit = 0;

   wt_cache dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (req),
      .addr           (addr),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .rdata          (rdata),
      .ack            (ack),
      .be_req         (be_req),
      .be_addr        (be_addr),
      .be_wdata       (be_wdata),
      .be_wstrb       (be_wstrb),
      .be_rdata       (be_rdata),
      .be_ack         (be_ack),
      .invalidate_in  (invalidate_in),
      .invalidate_out (invalidate_out),
      .wtb_empty_in   (wtb_empty_in),
      .wtb_empty_out  (wtb_empty_out)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Memory model that acks each transfer after 1 to 3 cycles
   initial begin : memory_model
      logic [31:0] seed;
      logic [1:0]  wait_left;
      logic        serving;
      seed = SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         seed   = lcg_next(seed);
         mem[i] = seed;
      end
      serving   = 1'b0;
      wait_left = 2'd0;
      be_ack   <= 1'b0;
      be_rdata <= '0;
      forever begin
         @(posedge clk);
         be_ack <= 1'b0;
         if (be_req && !be_ack) begin  // Skip the cycle the ack is already out
            if (!serving) begin
               seed      = lcg_next(seed);
               wait_left = seed[25:24] % 2'd3;
               serving   = 1'b1;
            end
            if (wait_left != 2'd0) begin
               wait_left = wait_left - 2'd1;
            end else begin
               serving   = 1'b0;
               be_ack   <= 1'b1;
               be_rdata <= mem[be_addr];
               for (int b = 0; b < 4; b++) begin
                  if (be_wstrb[b]) mem[be_addr][8*b +: 8] = be_wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic add_op(input string name, input op_kind_t kind, input word_addr_t a,
                         input data_t wd, input strb_t ws, input logic use_exp,
                         input data_t exp);
      op_name.push_back(name);
      op_kind.push_back(kind);
      op_addr.push_back(a);
      op_wdata.push_back(wd);
      op_wstrb.push_back(ws);
      op_use_exp.push_back(use_exp);
      op_exp.push_back(exp);
   endtask

   // Lines A and B share index 1 while C, D and E sit at index 4, 8 and 13
   task automatic build_table();
      add_op("rd_miss_a",      OP_RD,  14'h0104, '0, 4'h0, 1'b0, '0);
      add_op("rd_hit_a1",      OP_RD,  14'h0105, '0, 4'h0, 1'b0, '0);
      add_op("cnt_rd_miss_1",  OP_CRD, {11'd0, CTRL_RD_MISS}, '0, 4'h0, 1'b0, '0);
      add_op("cnt_rd_hit_1",   OP_CRD, {11'd0, CTRL_RD_HIT}, '0, 4'h0, 1'b0, '0);
      add_op("rd_fill_c",      OP_RD,  14'h0312, '0, 4'h0, 1'b0, '0);
      add_op("wr_hit_c",       OP_WR,  14'h0312, 32'hA5A5_5A5A, 4'b0101, 1'b0, '0);
      add_op("rd_merged_c",    OP_RD,  14'h0312, '0, 4'h0, 1'b0, '0);
      add_op("wr_miss_d",      OP_WR,  14'h0520, 32'h1234_5678, 4'b1100, 1'b0, '0);
      add_op("cnt_wr_hit_1",   OP_CRD, {11'd0, CTRL_WR_HIT}, '0, 4'h0, 1'b0, '0);
      add_op("cnt_wr_miss_1",  OP_CRD, {11'd0, CTRL_WR_MISS}, '0, 4'h0, 1'b0, '0);
      add_op("rd_miss_d",      OP_RD,  14'h0520, '0, 4'h0, 1'b0, '0);
      add_op("rd_evict_b",     OP_RD,  14'h0204, '0, 4'h0, 1'b0, '0);
      add_op("rd_evict_a",     OP_RD,  14'h0104, '0, 4'h0, 1'b0, '0);
      add_op("rd_evict_b3",    OP_RD,  14'h0207, '0, 4'h0, 1'b0, '0);
      add_op("rd_evict_a2",    OP_RD,  14'h0106, '0, 4'h0, 1'b0, '0);
      add_op("cnt_rd_miss_2",  OP_CRD, {11'd0, CTRL_RD_MISS}, '0, 4'h0, 1'b0, '0);
      add_op("status_idle",    OP_CRD, {11'd0, CTRL_STATUS}, '0, 4'h0, 1'b1, 32'd1);
      add_op("empty_high",     OP_EMPTY, '0, 32'd1, 4'h0, 1'b0, '0);
      add_op("empty_low",      OP_EMPTY, '0, 32'd0, 4'h0, 1'b0, '0);
      add_op("empty_back",     OP_EMPTY, '0, 32'd1, 4'h0, 1'b0, '0);
      add_op("rd_hit_c",       OP_RD,  14'h0313, '0, 4'h0, 1'b0, '0);
      add_op("ctl_invalidate", OP_CWR, {11'd0, CTRL_INVALIDATE}, 32'd1, 4'hF, 1'b0, '0);
      add_op("rd_inv_miss_c",  OP_RD,  14'h0310, '0, 4'h0, 1'b0, '0);
      add_op("pin_invalidate", OP_PIN, '0, '0, 4'h0, 1'b0, '0);
      add_op("rd_pin_miss_c",  OP_RD,  14'h0311, '0, 4'h0, 1'b0, '0);
      add_op("wr_full_c",      OP_WR,  14'h0311, 32'hDEAD_BEEF, 4'hF, 1'b0, '0);
      add_op("rd_full_c",      OP_RD,  14'h0311, '0, 4'h0, 1'b0, '0);
      add_op("wr_byte_e",      OP_WR,  14'h0734, 32'h0000_00C3, 4'b0001, 1'b0, '0);
      add_op("rd_byte_e",      OP_RD,  14'h0734, '0, 4'h0, 1'b0, '0);
      add_op("cnt_rd_hit_2",   OP_CRD, {11'd0, CTRL_RD_HIT}, '0, 4'h0, 1'b0, '0);
      add_op("cnt_rd_miss_3",  OP_CRD, {11'd0, CTRL_RD_MISS}, '0, 4'h0, 1'b0, '0);
      add_op("cnt_wr_hit_2",   OP_CRD, {11'd0, CTRL_WR_HIT}, '0, 4'h0, 1'b0, '0);
      add_op("cnt_wr_miss_2",  OP_CRD, {11'd0, CTRL_WR_MISS}, '0, 4'h0, 1'b0, '0);
      add_op("ctl_clear",      OP_CWR, {11'd0, CTRL_CLEAR}, 32'd1, 4'hF, 1'b0, '0);
      add_op("zero_rd_hit",    OP_CRD, {11'd0, CTRL_RD_HIT}, '0, 4'h0, 1'b1, '0);
      add_op("zero_rd_miss",   OP_CRD, {11'd0, CTRL_RD_MISS}, '0, 4'h0, 1'b1, '0);
      add_op("zero_wr_hit",    OP_CRD, {11'd0, CTRL_WR_HIT}, '0, 4'h0, 1'b1, '0);
      add_op("zero_wr_miss",   OP_CRD, {11'd0, CTRL_WR_MISS}, '0, 4'h0, 1'b1, '0);
      add_op("status_end",     OP_CRD, {11'd0, CTRL_STATUS}, '0, 4'h0, 1'b1, 32'd1);
   endtask

   // Reference model that updates shadow state and returns the expected rdata
   function automatic data_t predict(input int i);
      word_addr_t wa;
      index_t     idx;
      tag_t       tag;
      logic       hit;
      data_t      res;
      wa  = op_addr[i];
      idx = wa[5:2];   // Word address is tag | index | offset
      tag = wa[13:6];
      hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
      res = '0;
      case (op_kind[i])
         OP_RD: begin
            if (hit) begin
               exp_cnt[0] = exp_cnt[0] + 1;
            end else begin
               exp_cnt[1]        = exp_cnt[1] + 1;
               shadow_valid[idx] = 1'b1;  // Line filled on the miss
               shadow_tag[idx]   = tag;
            end
            res = shadow[wa];
         end
         OP_WR: begin
            if (hit) exp_cnt[2] = exp_cnt[2] + 1;
            else exp_cnt[3] = exp_cnt[3] + 1;  // No allocation on a write miss
            for (int b = 0; b < 4; b++) begin
               if (op_wstrb[i][b]) shadow[wa][8*b +: 8] = op_wdata[i][8*b +: 8];
            end
         end
         OP_CRD: begin
            if (op_use_exp[i]) res = op_exp[i];
            else if (wa[2:0] <= CTRL_WR_MISS) res = exp_cnt[wa[1:0]];
         end
         OP_CWR: begin
            if (wa[2:0] == CTRL_INVALIDATE) shadow_valid = '0;
            if (wa[2:0] == CTRL_CLEAR) begin
               for (int k = 0; k < 4; k++) exp_cnt[k] = '0;
            end
         end
         default: ;
      endcase
      return res;
   endfunction

   task automatic check_value(input string name, input data_t exp, input data_t got);
      assert (got === exp) else begin
         $display("ERROR %s: expected %h, actual %h", name, exp, got);
         test_ok = 1'b0;
      end
   endtask

   // One host transfer held until ack
   task automatic host_access(input int i, output data_t got, output logic saw_busy);
      logic is_ctrl;
      is_ctrl  = (op_kind[i] == OP_CRD) || (op_kind[i] == OP_CWR);
      saw_busy = 1'b0;
      @(posedge clk);
      req   <= 1'b1;
      addr  <= {is_ctrl, op_addr[i]};
      wdata <= op_wdata[i];
      wstrb <= op_wstrb[i];
      do begin
         @(negedge clk);
         if (!wtb_empty_out) saw_busy = 1'b1;  // Write still in flight
      end while (!ack);
      got = rdata;
      @(posedge clk);
      req   <= 1'b0;
      wstrb <= '0;
   endtask

   task automatic pulse_invalidate(input int i);
      @(posedge clk);
      invalidate_in <= 1'b1;
      @(negedge clk);
      check_value({op_name[i], " invalidate_out"}, 32'd1, data_t'(invalidate_out));
      @(posedge clk);
      invalidate_in <= 1'b0;
      @(negedge clk);
      check_value({op_name[i], " invalidate_out"}, 32'd0, data_t'(invalidate_out));
      shadow_valid = '0;  // Flush seen by the cache too
   endtask

   task automatic drive_empty(input int i);
      @(posedge clk);
      wtb_empty_in <= op_wdata[i][0];
      @(negedge clk);
      check_value({op_name[i], " wtb_empty_out"}, data_t'(op_wdata[i][0]),
                  data_t'(wtb_empty_out));
   endtask

   task automatic run_op(input int i);
      data_t exp;
      data_t got;
      logic  saw_busy;
      test_ok = 1'b1;
      case (op_kind[i])
         OP_PIN:   pulse_invalidate(i);
         OP_EMPTY: drive_empty(i);
         default: begin
            exp = predict(i);
            host_access(i, got, saw_busy);
            if (op_kind[i] == OP_WR) begin
               check_value({op_name[i], " memory"}, shadow[op_addr[i]], mem[op_addr[i]]);
               assert (saw_busy) else begin
                  $display("%s: wtb_empty_out never dropped during the write", op_name[i]);
                  test_ok = 1'b0;
               end
            end else begin
               check_value(op_name[i], exp, got);  // Commands answer with zero
            end
         end
      endcase
      if (test_ok) begin
         n_pass++;
         $display("%-16s passed", op_name[i]);
      end else begin
         n_fail++;
         $display("%-16s FAILED", op_name[i]);
      end
   endtask

   initial begin : stimulus
      logic [31:0] seed;
      seed = SEED;  // Same sequence as the memory model
      for (int i = 0; i < MEM_WORDS; i++) begin
         seed      = lcg_next(seed);
         shadow[i] = seed;
      end
      shadow_valid = '0;
      for (int k = 0; k < 4; k++) exp_cnt[k] = '0;
      build_table();
      cycle_limit = op_name.size() * CYCLES_PER_OP + RST_CYCLES;
      rst_n         <= 1'b0;
      req           <= 1'b0;
      addr          <= '0;
      wdata         <= '0;
      wstrb         <= '0;
      invalidate_in <= 1'b0;
      wtb_empty_in  <= 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < op_name.size(); i++) run_op(i);
      $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== wt_cache.f ====
logic/wt_cache_pkg.sv
logic/wt_cache_front_end.sv
logic/wt_cache_memory.sv
logic/wt_cache_back_end.sv
logic/wt_cache_control.sv
logic/wt_cache.sv
verif/wt_cache_tb.sv
